// File: design/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl import cache_geom_pkg::*, cache_op_pkg::*; #(
    parameter int  NUM_WAYS = L2_WAYS_DEF,
    localparam int WAY_W    = $clog2(NUM_WAYS)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  addr_t            paddr,
    input  byte_t            pwdata,
    output byte_t            prdata,
    output logic             pready,
    output logic             hit1,
    output logic             hit2,
    output l1_idx_t          l1_index,
    output l1_tag_t          l1_tag,
    input  logic             l1_hit,
    input  line_t            l1_rline,
    input  l1_tag_t          l1_vtag,
    input  logic             l1_vvalid,
    output logic             l1_fill,
    output line_t            l1_fill_line,
    output logic             l1_wbyte,
    output l2_idx_t          l2_set,
    output l2_tag_t          l2_tag,
    input  logic             l2_hit,
    input  logic [WAY_W-1:0] l2_hit_way,
    output logic [WAY_W-1:0] l2_way,
    input  line_t            l2_rline,
    input  l2_tag_t          l2_vtag,
    input  logic             l2_vvalid,
    output logic             l2_fill,
    output line_t            l2_fill_line,
    output logic             l2_wline,
    output logic             l2_wbyte,
    output logic             lru_touch,
    output logic [WAY_W-1:0] lru_way,
    input  logic [WAY_W-1:0] lru_victim,
    output blk_t             mem_blk,
    input  line_t            mem_rdata,
    output logic             mem_wline,
    output logic             mem_wbyte,
    output line_t            mem_wdata,
    output offset_t          offset,
    output byte_t            wdata
);
    // V2 writes back the l2 victim, V1 the l1 victim
    typedef enum logic [2:0] {S_IDLE, S_LOOK, S_V2, S_MRD, S_FILL2, S_V1, S_FILL1} state_t;

    state_t           state_q, state_d;
    addr_t            addr_q;
    acc_t             kind_q;
    byte_t            wdata_q;
    logic [WAY_W-1:0] way_q;     // l2 way holding the requested block
    serve_t           serve_q, serve_d, rsp_serve;
    blk_t             req_blk, l1v_blk, l2v_blk;
    line_t            rsp_line;
    logic             start, done;

    assign req_blk  = addr_blk(addr_q);
    assign l1_index = l1_index_of(req_blk);
    assign l1_tag   = l1_tag_of(req_blk);
    assign offset   = addr_off(addr_q);
    assign wdata    = wdata_q;
    assign l1v_blk  = {l1_vtag, l1_index};
    assign l2v_blk  = {l2_vtag, l2_set_of(req_blk)};
    assign l1_fill_line = l2_rline;    // l1 is only ever filled from l2

    assign start     = (state_q == S_IDLE) && psel && penable && !pready;
    assign serve_d   = l1_hit ? SERVE_L1 : (l2_hit ? SERVE_L2 : SERVE_MEM);
    assign done      = ((state_q == S_LOOK) && (kind_q == ACC_WRITE || l1_hit))
                       || (state_q == S_FILL1);
    assign rsp_serve = (state_q == S_LOOK) ? serve_d : serve_q;
    assign rsp_line  = (state_q == S_LOOK) ? l1_rline : l2_rline;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_IDLE:  if (start) state_d = S_LOOK;
            S_LOOK:
            begin
                if (kind_q == ACC_WRITE || l1_hit)
                    state_d = S_IDLE;
                else if (l2_hit)
                    state_d = l1_vvalid ? S_V1 : S_FILL1;
                else
                    state_d = S_V2;
            end
            S_V2:    state_d = l2_vvalid ? S_MRD : S_FILL2;    // no writeback, read already issued
            S_MRD:   state_d = S_FILL2;
            S_FILL2: state_d = l1_vvalid ? S_V1 : S_FILL1;
            S_V1:    state_d = S_FILL1;
            default: state_d = S_IDLE;
        endcase
    end

    always_comb
    begin
        l1_fill      = 1'b0;
        l1_wbyte     = 1'b0;
        l2_fill      = 1'b0;
        l2_wline     = 1'b0;
        l2_wbyte     = 1'b0;
        lru_touch    = 1'b0;
        mem_wline    = 1'b0;
        mem_wbyte    = 1'b0;
        l2_set       = l2_set_of(req_blk);
        l2_tag       = l2_tag_of(req_blk);
        l2_way       = way_q;
        lru_way      = way_q;
        l2_fill_line = mem_rdata;
        mem_blk      = req_blk;
        mem_wdata    = l2_rline;
        case (state_q)
            S_LOOK:
            begin
                l2_way = l2_hit_way;
                if (kind_q == ACC_WRITE)
                begin
                    // no allocate, the first level that holds the block takes the byte
                    l1_wbyte  = l1_hit;
                    l2_wbyte  = !l1_hit && l2_hit;
                    mem_wbyte = !l1_hit && !l2_hit;
                end
                else if (!l1_hit)
                begin
                    lru_touch = 1'b1;
                    lru_way   = l2_hit ? l2_hit_way : lru_victim;
                end
            end
            S_V2:
            begin
                mem_blk   = l2_vvalid ? l2v_blk : req_blk;
                mem_wline = l2_vvalid;
            end
            S_FILL2: l2_fill = 1'b1;
            S_V1:
            begin
                // look the l1 victim up through the same l2 compare path
                l2_set       = l2_set_of(l1v_blk);
                l2_tag       = l2_tag_of(l1v_blk);
                l2_way       = l2_hit_way;
                l2_fill_line = l1_rline;
                mem_blk      = l1v_blk;
                mem_wdata    = l1_rline;
                l2_wline     = l2_hit;
                mem_wline    = !l2_hit;
            end
            S_FILL1: l1_fill = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= S_IDLE;
            pready  <= 1'b0;
            hit1    <= 1'b0;
            hit2    <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            pready  <= done;    // one cycle only, the fsm is back in idle
            if (done)
            begin
                hit1 <= (rsp_serve == SERVE_L1);
                hit2 <= (rsp_serve == SERVE_L2);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            addr_q  <= paddr;
            kind_q  <= pwrite ? ACC_WRITE : ACC_READ;
            wdata_q <= pwdata;
        end
        if (state_q == S_LOOK)
        begin
            serve_q <= serve_d;
            way_q   <= l2_hit ? l2_hit_way : lru_victim;
        end
        if (done)
            prdata <= (kind_q == ACC_WRITE) ? 8'h00 : line_byte(rsp_line, offset);
    end

endmodule

// File: design/cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int ADDR_W = 11;
    localparam int OFF_W  = 2;
    localparam int BLK_W  = ADDR_W - OFF_W;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [BLK_W-1:0]  blk_t;    // memory block number
    typedef logic [7:0]        byte_t;
    typedef logic [31:0]       line_t;   // one block of four bytes
    typedef logic [OFF_W-1:0]  offset_t;

    localparam int L1_LINES = 8;
    typedef logic [2:0] l1_idx_t;
    typedef logic [5:0] l1_tag_t;

    localparam int L2_WAYS_DEF = 4;
    localparam int L2_SETS     = 16;
    typedef logic [3:0] l2_idx_t;
    typedef logic [4:0] l2_tag_t;

    localparam int MEM_BLOCKS = 512;

    function automatic blk_t addr_blk(addr_t a);
        return a[ADDR_W-1:OFF_W];
    endfunction

    function automatic offset_t addr_off(addr_t a);
        return a[OFF_W-1:0];
    endfunction

    // block number split for the two caches
    function automatic l1_idx_t l1_index_of(blk_t b);
        return b[2:0];
    endfunction

    function automatic l1_tag_t l1_tag_of(blk_t b);
        return b[BLK_W-1:3];
    endfunction

    function automatic l2_idx_t l2_set_of(blk_t b);
        return b[3:0];
    endfunction

    function automatic l2_tag_t l2_tag_of(blk_t b);
        return b[BLK_W-1:4];
    endfunction

    function automatic byte_t line_byte(line_t l, offset_t off);
        return l[off*8 +: 8];    // byte 0 sits in the low bits
    endfunction

endpackage

// File: design/cache_op_pkg.sv
package cache_op_pkg;

    // direction of one APB transfer
    typedef enum logic {
        ACC_READ  = 1'b0,
        ACC_WRITE = 1'b1
    } acc_t;

    // level that answered the access
    typedef enum logic [1:0] {
        SERVE_L1  = 2'd0,
        SERVE_L2  = 2'd1,
        SERVE_MEM = 2'd2
    } serve_t;

endpackage

// File: design/cache_top.sv
`timescale 1ns/1ns

module cache_top import cache_geom_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  addr_t paddr,
    input  byte_t pwdata,
    output byte_t prdata,
    output logic  pready,
    output logic  hit1,
    output logic  hit2
);
    localparam int NUM_WAYS = L2_WAYS_DEF;
    localparam int WAY_W    = $clog2(NUM_WAYS);

    // l1 side
    l1_idx_t l1_index;
    l1_tag_t l1_tag;
    logic    l1_hit;
    line_t   l1_rline;
    l1_tag_t l1_vtag;
    logic    l1_vvalid;
    logic    l1_fill;
    line_t   l1_fill_line;
    logic    l1_wbyte;

    // l2 side
    l2_idx_t          l2_set;
    l2_tag_t          l2_tag;
    logic             l2_hit;
    logic [WAY_W-1:0] l2_hit_way;
    logic [WAY_W-1:0] l2_way;
    line_t            l2_rline;
    l2_tag_t          l2_vtag;
    logic             l2_vvalid;
    logic             l2_fill;
    line_t            l2_fill_line;
    logic             l2_wline;
    logic             l2_wbyte;

    logic             lru_touch;
    logic [WAY_W-1:0] lru_way;
    logic [WAY_W-1:0] lru_victim;

    blk_t    mem_blk;
    line_t   mem_rdata;
    logic    mem_wline;
    logic    mem_wbyte;
    line_t   mem_wdata;
    offset_t req_offset;    // byte lane of the current request
    byte_t   req_wdata;

    cache_ctrl #(.NUM_WAYS(NUM_WAYS)) u_ctrl (.*, .offset(req_offset), .wdata(req_wdata));

    l1_array u_l1 (
        .clk, .rst_n, .index(l1_index), .tag(l1_tag), .hit(l1_hit), .rline(l1_rline),
        .victim_tag(l1_vtag), .victim_valid(l1_vvalid), .fill(l1_fill),
        .fill_line(l1_fill_line), .wbyte(l1_wbyte), .offset(req_offset), .wdata(req_wdata)
    );

    l2_array #(.NUM_WAYS(NUM_WAYS)) u_l2 (
        .clk, .rst_n, .set(l2_set), .tag(l2_tag), .hit(l2_hit), .hit_way(l2_hit_way),
        .way(l2_way), .rline(l2_rline), .vtag(l2_vtag), .vvalid(l2_vvalid), .fill(l2_fill),
        .fill_line(l2_fill_line), .wline(l2_wline), .wbyte(l2_wbyte), .offset(req_offset),
        .wdata(req_wdata)
    );

    // ages are kept for whichever set the controller presents to l2
    lru_tracker #(.NUM_WAYS(NUM_WAYS)) u_lru (
        .clk, .rst_n, .set(l2_set), .touch(lru_touch), .way(lru_way), .victim(lru_victim)
    );

    main_mem u_mem (
        .clk, .blk(mem_blk), .rdata(mem_rdata), .wline(mem_wline), .line_data(mem_wdata),
        .wbyte(mem_wbyte), .offset(req_offset), .wdata(req_wdata)
    );

endmodule

// File: design/l1_array.sv
`timescale 1ns/1ns

module l1_array import cache_geom_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  l1_idx_t index,
    input  l1_tag_t tag,
    output logic    hit,
    output line_t   rline,
    output l1_tag_t victim_tag,
    output logic    victim_valid,
    input  logic    fill,
    input  line_t   fill_line,
    input  logic    wbyte,
    input  offset_t offset,
    input  byte_t   wdata
);
    line_t               data_q [L1_LINES];
    l1_tag_t             tag_q  [L1_LINES];
    logic [L1_LINES-1:0] valid_q;

    // current line as seen by lookup and eviction
    assign rline        = data_q[index];
    assign victim_tag   = tag_q[index];
    assign victim_valid = valid_q[index];
    assign hit          = valid_q[index] && (tag_q[index] == tag);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            valid_q <= '0;
        else if (fill)
            valid_q[index] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            data_q[index] <= fill_line;
            tag_q[index]  <= tag;
        end
        else if (wbyte)
            data_q[index][offset*8 +: 8] <= wdata;
    end

endmodule

// File: design/l2_array.sv
`timescale 1ns/1ns

module l2_array import cache_geom_pkg::*; #(
    parameter int  NUM_WAYS = L2_WAYS_DEF,
    localparam int WAY_W    = $clog2(NUM_WAYS)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  l2_idx_t          set,
    input  l2_tag_t          tag,
    output logic             hit,
    output logic [WAY_W-1:0] hit_way,
    input  logic [WAY_W-1:0] way,
    output line_t            rline,
    output l2_tag_t          vtag,
    output logic             vvalid,
    input  logic             fill,
    input  line_t            fill_line,
    input  logic             wline,
    input  logic             wbyte,
    input  offset_t          offset,
    input  byte_t            wdata
);
    line_t               data_q  [L2_SETS][NUM_WAYS];
    l2_tag_t             tag_q   [L2_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [L2_SETS];

    // all ways of the set compared at once
    always_comb
    begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (valid_q[set][w] && (tag_q[set][w] == tag))
            begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
        end
    end

    assign rline  = data_q[set][way];
    assign vtag   = tag_q[set][way];    // tag of the selected way, used for eviction
    assign vvalid = valid_q[set][way];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < L2_SETS; s++)
                valid_q[s] <= '0;
        end
        else if (fill)
            valid_q[set][way] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            data_q[set][way] <= fill_line;
            tag_q[set][way]  <= tag;
        end
        else if (wline)
            data_q[set][way] <= fill_line;    // l1 victim written back, tag unchanged
        else if (wbyte)
            data_q[set][way][offset*8 +: 8] <= wdata;
    end

endmodule

// File: design/lru_tracker.sv
`timescale 1ns/1ns

module lru_tracker import cache_geom_pkg::*; #(
    parameter int  NUM_WAYS = L2_WAYS_DEF,
    localparam int WAY_W    = $clog2(NUM_WAYS)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  l2_idx_t          set,
    input  logic             touch,
    input  logic [WAY_W-1:0] way,
    output logic [WAY_W-1:0] victim
);
    // age 0 is least recently used, NUM_WAYS-1 most recent
    logic [WAY_W-1:0] age_q [L2_SETS][NUM_WAYS];

    always_comb
    begin
        victim = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (age_q[set][w] == '0)
                victim = WAY_W'(w);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < L2_SETS; s++)
                for (int w = 0; w < NUM_WAYS; w++)
                    age_q[s][w] <= WAY_W'(w);    // ages start equal to way numbers
        end
        else if (touch)
        begin
            for (int w = 0; w < NUM_WAYS; w++)
            begin
                if (WAY_W'(w) == way)
                    age_q[set][w] <= WAY_W'(NUM_WAYS - 1);
                else if (age_q[set][w] > age_q[set][way])
                    age_q[set][w] <= age_q[set][w] - 1'b1;    // younger ways step down
            end
        end
    end

endmodule

// File: design/main_mem.sv
`timescale 1ns/1ns

module main_mem import cache_geom_pkg::*; (
    input  logic    clk,
    input  blk_t    blk,
    output line_t   rdata,
    input  logic    wline,
    input  line_t   line_data,
    input  logic    wbyte,
    input  offset_t offset,
    input  byte_t   wdata
);
    line_t mem [MEM_BLOCKS];

    // every block starts out holding its own block number
    initial
    begin
        for (int i = 0; i < MEM_BLOCKS; i++)
            mem[i] = line_t'(i);
    end

    always_ff @(posedge clk)
    begin
        if (wline)
            mem[blk] <= line_data;
        else if (wbyte)
            mem[blk][offset*8 +: 8] <= wdata;
        rdata <= mem[blk];    // registered read, old data on a write
    end

endmodule

// File: run.sh
#!/bin/sh
# build the cache testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_tb -f src.f -o cache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    echo "result: pass"
    exit 0
fi

echo "result: fail"
exit 1

// File: src.f
design/cache_geom_pkg.sv
design/cache_op_pkg.sv
design/l1_array.sv
design/l2_array.sv
design/lru_tracker.sv
design/main_mem.sv
design/cache_ctrl.sv
design/cache_top.sv
verif/cache_chk.sv
verif/cache_tb.sv

// File: verif/cache_chk.sv
`timescale 1ns/1ns

module cache_chk (
    input logic clk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic hit1,
    input logic hit2
);
    logic [3:0] busy_cycles;    // access cycles so far without pready

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            busy_cycles <= '0;
        else if (psel && penable && !pready)
            busy_cycles <= busy_cycles + 1'b1;
        else
            busy_cycles <= '0;
    end

    pready_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) pready |=> !pready)
        else $error("pready stayed high for more than one cycle");

    pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
                                       pready |-> (psel && penable))
        else $error("pready raised outside an access cycle");

    // a transfer is served by one level at most
    hits_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(hit1 && hit2))
        else $error("hit1 and hit2 both high");

    access_bounded: assert property (@(posedge clk) disable iff (!rst_n) busy_cycles < 4'd8)
        else $error("access took more than 8 cycles");

endmodule

// File: verif/cache_tb.sv
`timescale 1ns/1ns

module cache_tb import cache_geom_pkg::*, cache_op_pkg::*;;
    localparam int CLK_NS       = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_DIRECTED = 34;
    localparam int NUM_RANDOM   = 400;
    // each transfer takes at most about 10 cycles so 12 leaves a margin
    localparam int WATCHDOG_NS  = ((NUM_DIRECTED + NUM_RANDOM) * 12 + RESET_CYCLES) * CLK_NS;

    typedef struct packed {
        logic   is_write;
        addr_t  addr;
        byte_t  rdata;
        serve_t serve;
    } expect_t;

    logic  clk;
    logic  rst_n;
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    byte_t pwdata;
    byte_t prdata;
    logic  pready;
    logic  hit1;
    logic  hit2;

    // reference keeps only tags and ages while data lives in one flat memory
    line_t   model_mem    [MEM_BLOCKS];
    l1_tag_t model_l1_tag [L1_LINES];
    logic    model_l1_vld [L1_LINES];
    l2_tag_t model_l2_tag [L2_SETS][L2_WAYS_DEF];
    logic    model_l2_vld [L2_SETS][L2_WAYS_DEF];
    int      model_age    [L2_SETS][L2_WAYS_DEF];

    expect_t pending [$];    // one entry per transfer in flight
    expect_t cur;
    integer  seed;
    int      rnd;

    cache_top DUT (.*);

    bind cache_ctrl cache_chk u_chk (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pready(pready),
        .hit1(hit1), .hit2(hit2)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    task automatic end_in_failure();
        $display("TB FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic void reset_model();
        for (int b = 0; b < MEM_BLOCKS; b++)
            model_mem[b] = line_t'(b);    // each block starts as its own number
        for (int i = 0; i < L1_LINES; i++)
            model_l1_vld[i] = 1'b0;
        for (int s = 0; s < L2_SETS; s++)
        begin
            for (int w = 0; w < L2_WAYS_DEF; w++)
            begin
                model_l2_vld[s][w] = 1'b0;
                model_age[s][w]    = w;
            end
        end
    endfunction

    function automatic int find_l2_way(int set, l2_tag_t tag);
        int way;
        way = -1;
        for (int w = 0; w < L2_WAYS_DEF; w++)
            if (model_l2_vld[set][w] && model_l2_tag[set][w] == tag)
                way = w;
        return way;
    endfunction

    function automatic int oldest_way(int set);
        int way;
        way = 0;
        for (int w = 0; w < L2_WAYS_DEF; w++)
            if (model_age[set][w] == 0)
                way = w;
        return way;
    endfunction

    // ways younger than the touched one age by one step
    function automatic void touch_lru(int set, int way);
        int old_age;
        old_age = model_age[set][way];
        for (int w = 0; w < L2_WAYS_DEF; w++)
            if (model_age[set][w] > old_age)
                model_age[set][w]--;
        model_age[set][way] = L2_WAYS_DEF - 1;
    endfunction

    function automatic expect_t predict_access(logic is_write, addr_t addr, byte_t data);
        expect_t e;
        int      blk;
        int      off;
        int      idx;
        int      set;
        int      way;
        blk = int'(addr[10:2]);
        off = int'(addr[1:0]);
        idx = blk % L1_LINES;
        set = blk % L2_SETS;
        way = find_l2_way(set, l2_tag_t'(blk / L2_SETS));
        e.is_write = is_write;
        e.addr     = addr;
        e.rdata    = model_mem[blk][off*8 +: 8];
        if (model_l1_vld[idx] && model_l1_tag[idx] == l1_tag_t'(blk / L1_LINES))
            e.serve = SERVE_L1;
        else if (way >= 0)
            e.serve = SERVE_L2;
        else
            e.serve = SERVE_MEM;
        if (is_write)
            model_mem[blk][off*8 +: 8] = data;    // writes never allocate
        else if (e.serve != SERVE_L1)
        begin
            if (way < 0)
            begin
                way = oldest_way(set);
                model_l2_tag[set][way] = l2_tag_t'(blk / L2_SETS);
                model_l2_vld[set][way] = 1'b1;
            end
            touch_lru(set, way);
            model_l1_tag[idx] = l1_tag_t'(blk / L1_LINES);
            model_l1_vld[idx] = 1'b1;
        end
        return e;
    endfunction

    function automatic addr_t addr_of(int blk, int off);
        return addr_t'(blk * 4 + off);
    endfunction

    task automatic apb_transfer(logic is_write, addr_t addr, byte_t data);
        @(negedge clk);
        pending.push_back(predict_access(is_write, addr, data));
        psel    = 1'b1;    // setup cycle
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        while (!pready)
            @(negedge clk);
    endtask

    task automatic read_byte(addr_t addr);
        apb_transfer(1'b0, addr, 8'h00);
    endtask

    task automatic write_byte(addr_t addr, byte_t data);
        apb_transfer(1'b1, addr, data);
    endtask

    always @(negedge clk)
    begin
        if (rst_n && pready)
        begin
            assert (pending.size() > 0) else
            begin
                $display("pready came back with no transfer outstanding");
                end_in_failure();
            end
            cur = pending.pop_front();
            if (!cur.is_write)
            begin
                assert (prdata == cur.rdata) else
                begin
                    $display("[FAIL] %0t ns: read of %h returned %h, expected %h",
                             $time, cur.addr, prdata, cur.rdata);
                    end_in_failure();
                end
            end
            assert (hit1 == (cur.serve == SERVE_L1) && hit2 == (cur.serve == SERVE_L2)) else
            begin
                $display("[FAIL] %0t ns: access to %h gave hit1=%b hit2=%b, expected %s",
                         $time, cur.addr, hit1, hit2, cur.serve.name());
                end_in_failure();
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns, the transfers did not all finish", WATCHDOG_NS);
        end_in_failure();
    end

    initial
    begin
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 32'hecf7;
        reset_model();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // cold reads and then the same blocks again out of l1
        read_byte(addr_of(1, 0));
        read_byte(addr_of(263, 1));
        read_byte(addr_of(1, 0));
        read_byte(addr_of(263, 0));

        // blocks 2 and 10 fight over l1 line 2
        for (int k = 0; k < 4; k++)
            read_byte(addr_of((k % 2 == 0) ? 2 : 10, 0));

        // five blocks of l2 set 5 push the first one out
        for (int k = 0; k < 5; k++)
            read_byte(addr_of(5 + 16 * k, 0));
        read_byte(addr_of(5, 0));

        read_byte(addr_of(100, 0));
        write_byte(addr_of(100, 2), 8'ha5);    // l1 hit
        read_byte(addr_of(200, 0));
        read_byte(addr_of(208, 0));            // pushes 200 out of l1
        write_byte(addr_of(200, 1), 8'h3c);    // l2 hit
        write_byte(addr_of(300, 3), 8'h77);    // not cached
        read_byte(addr_of(100, 2));
        read_byte(addr_of(200, 1));
        read_byte(addr_of(300, 3));
        // evict both written blocks through l1 and l2
        for (int k = 1; k <= 4; k++)
        begin
            read_byte(addr_of(100 + 16 * k, 0));
            read_byte(addr_of(200 + 16 * k, 0));
        end
        read_byte(addr_of(100, 2));
        read_byte(addr_of(200, 1));
        read_byte(addr_of(300, 3));

        // random mix with half of it inside a small window to get hits
        repeat (NUM_RANDOM)
        begin
            rnd = $random(seed);
            apb_transfer(rnd[31:30] == 2'b11,
                         rnd[9] ? addr_t'(rnd[20:10]) : addr_t'(rnd[8:0]), rnd[29:22]);
        end

        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        repeat (4) @(negedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule
